// ==== build.f ====
+incdir+design
design/bayer_pkg.sv
design/bayer_kernel.sv
design/bayer_phase.sv
design/bayer_interp.sv
design/demosaic_top.sv
test/demosaic_checker.sv
test/demosaic_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := demosaic_tb
FILELIST   := build.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
SIM_ARGS   := +verilator+error+limit+1000
PASS_MSG   := *** PASSED ***

SOURCES := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/demosaic_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bayer_defines.svh"

module demosaic_tb;

   import bayer_pkg::*;

   localparam int COLS        = 8;
   localparam int ROWS        = 6;
   localparam int NUM_FRAMES  = 12;
   localparam int FRAME_BEATS = 2 + ROWS * (COLS + 2);
   localparam int WATCHDOG    = NUM_FRAMES * FRAME_BEATS * 2 + 100;   // Gaps at most double

   logic                    clk = 1'b0;
   logic                    resetb;
   beat_t                   in;
   logic [1:0]              phase;
   logic                    dvo;
   logic [`DTYPE_WIDTH-1:0] dtypeo;
   logic [`DATA_WIDTH-1:0]  meta_datao;
   logic [`PIXEL_WIDTH-1:0] r;
   logic [`PIXEL_WIDTH-1:0] g;
   logic [`PIXEL_WIDTH-1:0] b;
   int                      errors = 0;
   int                      pix_count = 0;
   int                      frames_out = 0;

   demosaic_top dut0 (
      .clk        (clk),
      .resetb     (resetb),
      .in         (in),
      .phase      (phase),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .meta_datao (meta_datao),
      .r          (r),
      .g          (g),
      .b          (b)
   );

   always #50 clk = ~clk;

   function automatic logic [`DATA_WIDTH-1:0] random_word();
      int unsigned rnd;
      rnd = $urandom;
      return rnd[`DATA_WIDTH-1:0];
   endfunction

   task automatic drive_beat(input logic [`DTYPE_WIDTH-1:0] dtype,
                             input logic [`DATA_WIDTH-1:0]  word);
      @(posedge clk);
      #1;
      in.dv        = 1'b1;
      in.dtype     = dtype;
      in.word.meta = word;
   endtask

   task automatic drive_idle(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         #1;
         in = '0;
      end
   endtask

   // Values are given per site code, R G1 G2 B
   task automatic send_frame(input logic [1:0] ph, input logic [`DATA_WIDTH-1:0] val_r,
                             input logic [`DATA_WIDTH-1:0] val_g1,
                             input logic [`DATA_WIDTH-1:0] val_g2,
                             input logic [`DATA_WIDTH-1:0] val_b);
      logic [`DATA_WIDTH-1:0] vals [4];
      logic [1:0]             code;
      vals[0] = val_r;
      vals[1] = val_g1;
      vals[2] = val_g2;
      vals[3] = val_b;
      phase = ph;
      drive_beat(`DTYPE_FRAME_START, random_word());
      for (int y = 0; y < ROWS; y++) begin
         drive_beat(`DTYPE_ROW_START, random_word());
         for (int x = 0; x < COLS; x++) begin
            code = {ph[1] ^ y[0], ph[0] ^ x[0]};
            drive_beat(`DTYPE_PIXEL, {{`PAD_WIDTH{1'b0}}, vals[code][`PIXEL_WIDTH-1:0]});
            drive_idle($urandom_range(1, 0));
         end
         drive_beat(`DTYPE_ROW_END, random_word());
      end
      drive_beat(`DTYPE_FRAME_END, random_word());
      drive_idle(2);
   endtask

   // Output pixels per frame
   always @(posedge clk) begin
      if (dvo && dtypeo == `DTYPE_FRAME_START) begin
         pix_count = 0;
      end else if (dvo && dtypeo == `DTYPE_PIXEL) begin
         pix_count = pix_count + 1;
      end else if (dvo && dtypeo == `DTYPE_FRAME_END) begin
         if (pix_count != (COLS - 2) * (ROWS - 2)) begin
            errors = errors + 1;
            $display("error border_drop expected %0d actual %0d",
                     (COLS - 2) * (ROWS - 2), pix_count);
         end
         frames_out = frames_out + 1;
      end
   end

   initial begin
      logic [`DATA_WIDTH-1:0] v0;
      logic [`DATA_WIDTH-1:0] v1;
      logic [`DATA_WIDTH-1:0] v2;
      void'($urandom(32'hf071_f657));
      resetb = 1'b0;
      in     = '0;
      phase  = 2'd0;
      repeat (3) @(posedge clk);
      #1 resetb = 1'b1;
      drive_idle(3);
      for (int p = 0; p < 4; p++) begin   // Flat field
         v0 = random_word();
         send_frame(p[1:0], v0, v0, v0, v0);
      end
      for (int p = 0; p < 4; p++) begin   // One constant per site, G1 equal to G2
         v0 = random_word();
         v1 = random_word();
         v2 = random_word();
         send_frame(p[1:0], v0, v1, v1, v2);
      end
      for (int p = 0; p < 4; p++) begin   // Odd green sum so the half rounds up
         v0 = random_word();
         v1 = random_word();
         v2 = random_word();
         send_frame(p[1:0], v0, v1, v1 + 16'd1, v2);
      end
      wait (frames_out == NUM_FRAMES);
      repeat (2) @(posedge clk);
      $display("Run complete: %0d count errors, %0d assertion failures",
               errors, dut0.checker0.fail_count);
      if (errors == 0 && dut0.checker0.fail_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG * 100);
      $display("Watchdog expired after %0d cycles with %0d of %0d frames out",
               WATCHDOG, frames_out, NUM_FRAMES);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/demosaic_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bayer_defines.svh"

module demosaic_checker (
   input wire                    clk,
   input wire                    resetb,
   input wire bayer_pkg::beat_t  in,
   input wire [1:0]              phase,
   input wire                    dvo,
   input wire [`DTYPE_WIDTH-1:0] dtypeo,
   input wire [`DATA_WIDTH-1:0]  meta_datao,
   input wire [`PIXEL_WIDTH-1:0] r,
   input wire [`PIXEL_WIDTH-1:0] g,
   input wire [`PIXEL_WIDTH-1:0] b
);

   import bayer_pkg::*;

   localparam logic [`PIXEL_WIDTH+1:0] HALF_UP = 2;

   typedef struct packed {
      beat_t      beat;
      logic [1:0] centre;   // Site code of the window centre
      logic       border;
   } hist_t;

   hist_t                   hist1;
   hist_t                   hist2;   // Same beat as the outputs
   logic                    row_lat;
   logic                    col_lat;
   logic [7:0]              row_idx;
   logic [7:0]              col_idx;
   logic                    seen_beat;
   logic                    inner_pixel;
   logic [`PIXEL_WIDTH-1:0] site_val [4];   // Stimulus value per site in this frame
   int                      fail_count = 0;

   function automatic logic [`PIXEL_WIDTH-1:0] expected_green(
      input logic [1:0]              centre,
      input logic [`PIXEL_WIDTH-1:0] g1,
      input logic [`PIXEL_WIDTH-1:0] g2
   );
      logic [`PIXEL_WIDTH+1:0] twice_sum;
      twice_sum = {1'b0, g1, 1'b0} + {1'b0, g2, 1'b0} + HALF_UP;
      if (centre == site_g1) return g1;
      else if (centre == site_g2) return g2;
      else return twice_sum[`PIXEL_WIDTH+1:2];   // R and B see two of each green
   endfunction

   assign inner_pixel = hist2.beat.dv && (hist2.beat.dtype == `DTYPE_PIXEL) && !hist2.border;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         hist1     <= '0;
         hist2     <= '0;
         row_lat   <= 1'b0;
         col_lat   <= 1'b0;
         row_idx   <= '0;
         col_idx   <= '0;
         seen_beat <= 1'b0;
      end else begin
         // Centre is one row up and one column left of the input pixel
         hist1 <= '{beat: in, centre: {row_lat ^ ~row_idx[0], col_lat ^ ~col_idx[0]},
                    border: (row_idx < 8'd2) || (col_idx < 8'd2)};
         hist2 <= hist1;
         if (in.dv) seen_beat <= 1'b1;
         if (in.dv && in.dtype == `DTYPE_FRAME_START) begin
            row_lat <= phase[1];
            row_idx <= '0;
         end else if (in.dv && in.dtype == `DTYPE_ROW_END) begin
            row_idx <= row_idx + 8'd1;
         end
         if (in.dv && in.dtype == `DTYPE_ROW_START) begin
            col_lat <= phase[0];
            col_idx <= '0;
         end else if (in.dv && in.dtype == `DTYPE_PIXEL) begin
            col_idx <= col_idx + 8'd1;
         end
      end
   end

   // First two rows hold every site
   always_ff @(posedge clk) begin
      if (in.dv && in.dtype == `DTYPE_PIXEL && row_idx < 8'd2) begin
         site_val[{row_lat ^ row_idx[0], col_lat ^ col_idx[0]}] <= in.word.pix.sample;
      end
   end

   a_quiet_before_input: assert property (@(posedge clk) !seen_beat |-> !dvo)
      else begin
         fail_count = fail_count + 1;
         $error("reset: dvo high before the first input beat");
      end

   a_control_pass: assert property (@(posedge clk) disable iff (!resetb)
         hist2.beat.dv && hist2.beat.dtype != `DTYPE_PIXEL
         |-> dvo && dtypeo == hist2.beat.dtype && meta_datao == hist2.beat.word.meta)
      else begin
         fail_count = fail_count + 1;
         $error("control_pass: expected type %0d meta %h, actual dvo %b type %0d meta %h",
                hist2.beat.dtype, hist2.beat.word.meta, dvo, dtypeo, meta_datao);
      end

   a_border_drop: assert property (@(posedge clk) disable iff (!resetb)
         hist2.beat.dv && hist2.beat.dtype == `DTYPE_PIXEL && hist2.border |-> !dvo)
      else begin
         fail_count = fail_count + 1;
         $error("border_drop: a border pixel came out with dvo high");
      end

   a_pixel_colour: assert property (@(posedge clk) disable iff (!resetb)
         inner_pixel |-> dvo && dtypeo == `DTYPE_PIXEL && r == site_val[site_r]
         && g == expected_green(hist2.centre, site_val[site_g1], site_val[site_g2])
         && b == site_val[site_b])
      else begin
         fail_count = fail_count + 1;
         $error("pixel_colour: site %0d expected rgb %0d %0d %0d, actual %0d %0d %0d",
                hist2.centre, site_val[site_r],
                expected_green(hist2.centre, site_val[site_g1], site_val[site_g2]),
                site_val[site_b], r, g, b);
      end

endmodule

bind demosaic_top demosaic_checker checker0 (
   .clk        (clk),
   .resetb     (resetb),
   .in         (in),
   .phase      (phase),
   .dvo        (dvo),
   .dtypeo     (dtypeo),
   .meta_datao (meta_datao),
   .r          (r),
   .g          (g),
   .b          (b)
);

`default_nettype wire

// ==== design/demosaic_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bayer_defines.svh"

module demosaic_top (
   input  wire                     clk,
   input  wire                     resetb,
   input  wire bayer_pkg::beat_t   in,
   input  wire [1:0]               phase,
   output logic                    dvo,
   output logic [`DTYPE_WIDTH-1:0] dtypeo,
   output logic [`DATA_WIDTH-1:0]  meta_datao,
   output logic [`PIXEL_WIDTH-1:0] r,
   output logic [`PIXEL_WIDTH-1:0] g,
   output logic [`PIXEL_WIDTH-1:0] b
);

   import bayer_pkg::*;

   window_t win;    // Both arrive one cycle after the input beat
   site_t   site;

   bayer_kernel kernel0 (
      .clk    (clk),
      .resetb (resetb),
      .in     (in),
      .win    (win)
   );

   bayer_phase phase0 (
      .clk    (clk),
      .resetb (resetb),
      .in     (in),
      .phase  (phase),
      .site   (site)
   );

   bayer_interp interp0 (
      .clk        (clk),
      .resetb     (resetb),
      .win        (win),
      .site       (site),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .meta_datao (meta_datao),
      .r          (r),
      .g          (g),
      .b          (b)
   );

endmodule

`default_nettype wire

// ==== design/bayer_interp.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bayer_defines.svh"

module bayer_interp (
   input  wire                     clk,
   input  wire                     resetb,
   input  wire bayer_pkg::window_t win,
   input  wire bayer_pkg::site_t   site,
   output logic                    dvo,
   output logic [`DTYPE_WIDTH-1:0] dtypeo,
   output logic [`DATA_WIDTH-1:0]  meta_datao,
   output logic [`PIXEL_WIDTH-1:0] r,
   output logic [`PIXEL_WIDTH-1:0] g,
   output logic [`PIXEL_WIDTH-1:0] b
);

   import bayer_pkg::*;

   localparam logic [`PIXEL_WIDTH+1:0] ROUND_QUAD = 2;
   localparam logic [`PIXEL_WIDTH:0]   ROUND_PAIR = 1;

   logic [`PIXEL_WIDTH+1:0] plus_sum;     // Two guard bits for four terms
   logic [`PIXEL_WIDTH+1:0] diamond_sum;
   logic [`PIXEL_WIDTH:0]   vert_sum;
   logic [`PIXEL_WIDTH:0]   horz_sum;
   logic                    pixel_beat;

   assign plus_sum    = {2'b0, win.tc} + {2'b0, win.bc} + {2'b0, win.ml} + {2'b0, win.mr}
                        + ROUND_QUAD;
   assign diamond_sum = {2'b0, win.tl} + {2'b0, win.tr} + {2'b0, win.bl} + {2'b0, win.br}
                        + ROUND_QUAD;
   assign vert_sum    = {1'b0, win.tc} + {1'b0, win.bc} + ROUND_PAIR;
   assign horz_sum    = {1'b0, win.ml} + {1'b0, win.mr} + ROUND_PAIR;

   assign pixel_beat = win.dv && (win.dtype == `DTYPE_PIXEL);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo        <= 1'b0;
         dtypeo     <= '0;
         meta_datao <= '0;
         r          <= '0;
         g          <= '0;
         b          <= '0;
      end else begin
         dvo        <= win.dv && !(pixel_beat && site.border);   // Drop the border
         dtypeo     <= win.dtype;
         meta_datao <= win.word.meta;
         if (pixel_beat && !site.border) begin
            case (site.code)
               site_r: begin
                  r <= win.mc;
                  g <= plus_sum[`PIXEL_WIDTH+1:2];
                  b <= diamond_sum[`PIXEL_WIDTH+1:2];
               end
               site_g1: begin   // Red neighbours left and right
                  r <= horz_sum[`PIXEL_WIDTH:1];
                  g <= win.mc;
                  b <= vert_sum[`PIXEL_WIDTH:1];
               end
               site_g2: begin
                  r <= vert_sum[`PIXEL_WIDTH:1];
                  g <= win.mc;
                  b <= horz_sum[`PIXEL_WIDTH:1];
               end
               default: begin
                  r <= diamond_sum[`PIXEL_WIDTH+1:2];
                  g <= plus_sum[`PIXEL_WIDTH+1:2];
                  b <= win.mc;
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/bayer_phase.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bayer_defines.svh"

module bayer_phase (
   input  wire                   clk,
   input  wire                   resetb,
   input  wire bayer_pkg::beat_t in,
   input  wire [1:0]             phase,
   output bayer_pkg::site_t      site
);

   import bayer_pkg::*;

   logic       row_phase;
   logic       col_phase;
   logic [1:0] row_pos;     // Input row index, saturates at 2
   logic [1:0] col_pos;     // Input column index, saturates at 2
   logic       frame_start;
   logic       row_start;
   logic       row_end;
   logic       pixel_beat;
   site_t      site_next;

   assign frame_start = in.dv && (in.dtype == `DTYPE_FRAME_START);
   assign row_start   = in.dv && (in.dtype == `DTYPE_ROW_START);
   assign row_end     = in.dv && (in.dtype == `DTYPE_ROW_END);
   assign pixel_beat  = in.dv && (in.dtype == `DTYPE_PIXEL);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_phase <= 1'b0;
         col_phase <= 1'b0;
         row_pos   <= '0;
         col_pos   <= '0;
      end else begin
         if (frame_start) begin
            row_phase <= phase[1];
            row_pos   <= '0;
         end else if (row_end) begin
            row_phase <= ~row_phase;
            if (row_pos != 2'd2) row_pos <= row_pos + 1'b1;
         end
         if (row_start) begin
            col_phase <= phase[0];
            col_pos   <= '0;
         end else if (pixel_beat) begin
            col_phase <= ~col_phase;
            if (col_pos != 2'd2) col_pos <= col_pos + 1'b1;
         end
      end
   end

   // Centre lags one row and one column, so both phases are flipped
   always_comb begin
      site_next.code   = site_code_e'({~row_phase, ~col_phase});
      site_next.border = (row_pos < 2'd2) || (col_pos < 2'd2);
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) site <= '0;
      else         site <= site_next;
   end

endmodule

`default_nettype wire

// ==== design/bayer_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bayer_defines.svh"

module bayer_kernel (
   input  wire                clk,
   input  wire                resetb,
   input  wire bayer_pkg::beat_t in,
   output bayer_pkg::window_t win
);

   import bayer_pkg::*;

   // Oldest row and the row just before the current one
   logic [`PIXEL_WIDTH-1:0] line_old [`MAX_COLS];
   logic [`PIXEL_WIDTH-1:0] line_new [`MAX_COLS];

   logic [`COL_WIDTH-1:0]   col_addr;
   logic                    pixel_beat;
   logic                    row_start;
   logic [`PIXEL_WIDTH-1:0] top_in;
   logic [`PIXEL_WIDTH-1:0] mid_in;
   logic [`PIXEL_WIDTH-1:0] bot_in;
   window_t                 win_next;

   assign pixel_beat = in.dv && (in.dtype == `DTYPE_PIXEL);
   assign row_start  = in.dv && (in.dtype == `DTYPE_ROW_START);

   // New right column of the window
   assign top_in = line_old[col_addr];
   assign mid_in = line_new[col_addr];
   assign bot_in = in.word.pix.sample;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         col_addr <= '0;
      end else if (row_start) begin
         col_addr <= '0;
      end else if (pixel_beat) begin
         col_addr <= col_addr + 1'b1;   // Wraps at MAX_COLS
      end
   end

   // Each column moves down one row per pixel
   always_ff @(posedge clk) begin
      if (pixel_beat) begin
         line_old[col_addr] <= mid_in;
         line_new[col_addr] <= bot_in;
      end
   end

   always_comb begin
      win_next       = win;
      win_next.dv    = in.dv;
      win_next.dtype = in.dtype;
      win_next.word  = in.word;    // Control words ride along untouched
      if (pixel_beat) begin
         // Shift left by one column
         win_next.tl = win.tc;
         win_next.ml = win.mc;
         win_next.bl = win.bc;
         win_next.tc = win.tr;
         win_next.mc = win.mr;
         win_next.bc = win.br;
         win_next.tr = top_in;
         win_next.mr = mid_in;
         win_next.br = bot_in;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         win <= '0;
      end else begin
         win <= win_next;
      end
   end

endmodule

`default_nettype wire

// ==== design/bayer_pkg.sv ====
`default_nettype none
`include "bayer_defines.svh"

package bayer_pkg;

   // Pixel view of a stream word
   typedef struct packed {
      logic [`PAD_WIDTH-1:0]   pad;
      logic [`PIXEL_WIDTH-1:0] sample;    // Raw Bayer sample in the low bits
   } pixel_view_t;

   // Pixel beats read the sample, control beats read the whole word
   typedef union packed {
      pixel_view_t            pix;
      logic [`DATA_WIDTH-1:0] meta;
   } stream_word_u;

   typedef struct packed {
      logic                    dv;
      logic [`DTYPE_WIDTH-1:0] dtype;
      stream_word_u            word;
   } beat_t;

   // 3x3 neighbourhood plus the beat it belongs to
   typedef struct packed {
      logic [`PIXEL_WIDTH-1:0] tl, tc, tr;
      logic [`PIXEL_WIDTH-1:0] ml, mc, mr;
      logic [`PIXEL_WIDTH-1:0] bl, bc, br;
      logic                    dv;
      logic [`DTYPE_WIDTH-1:0] dtype;
      stream_word_u            word;
   } window_t;

   typedef enum logic [1:0] {
      site_r  = 2'd0,
      site_g1 = 2'd1,
      site_g2 = 2'd2,
      site_b  = 2'd3
   } site_code_e;

   typedef struct packed {
      site_code_e code;     // Bayer colour of the window centre
      logic       border;   // Centre has no full neighbourhood
   } site_t;

endpackage

`default_nettype wire

// ==== design/bayer_defines.svh ====
`ifndef BAYER_DEFINES_SVH
`define BAYER_DEFINES_SVH

// Sample and stream word sizes
`define PIXEL_WIDTH 10
`define DATA_WIDTH  16
`define PAD_WIDTH   (`DATA_WIDTH - `PIXEL_WIDTH)

// Line buffer depth and its address width
`define MAX_COLS    64
`define COL_WIDTH   6

`define DTYPE_WIDTH 3

// Beat type codes carried on dtype
`define DTYPE_FRAME_START 3'd1
`define DTYPE_ROW_START   3'd2
`define DTYPE_PIXEL       3'd3
`define DTYPE_ROW_END     3'd4
`define DTYPE_FRAME_END   3'd5

`endif
